//--- Bender.yml
package:
  name: uart_loader

sources:
  - source/loader_pkg.sv
  - source/tick_gen.sv
  - source/uart_rx.sv
  - source/byte_fifo.sv
  - source/imem_loader.sv
  - source/uart_tx.sv
  - source/uart_loader_top.sv
  - target: test
    files:
      - test/uart_loader_chk.sv
      - test/tb_uart_loader.sv

//--- build.f
source/loader_pkg.sv
source/tick_gen.sv
source/uart_rx.sv
source/byte_fifo.sv
source/imem_loader.sv
source/uart_tx.sv
source/uart_loader_top.sv
test/uart_loader_chk.sv
test/tb_uart_loader.sv

//--- source/byte_fifo.sv
// Byte FIFO with fall-through head, sits on both sides of the frame loader
`timescale 1ns/1ps

module byte_fifo (
   input  logic                     clk,
   input  logic                     arst_n,
   input  loader_pkg::byte_strobe_t push,
   input  logic                     pop,
   output loader_pkg::uart_byte_t   head,
   output logic                     empty,
   output logic                     full
);

   // Storage
   loader_pkg::uart_byte_t mem [2**loader_pkg::FIFO_AW];

   // Extra MSB tells full from empty
   logic [loader_pkg::FIFO_AW:0] wr_ptr;
   logic [loader_pkg::FIFO_AW:0] rd_ptr;
   logic                         do_push;
   logic                         do_pop;

   assign empty   = (wr_ptr == rd_ptr);
   assign full    = (wr_ptr[loader_pkg::FIFO_AW] != rd_ptr[loader_pkg::FIFO_AW]) &&
                    (wr_ptr[loader_pkg::FIFO_AW-1:0] == rd_ptr[loader_pkg::FIFO_AW-1:0]);
   // Overflowing push and underflowing pop are dropped
   assign do_push = push.valid && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[loader_pkg::FIFO_AW-1:0]] <= push.data;
      end
   end

   // Head is valid whenever empty is low
   assign head = mem[rd_ptr[loader_pkg::FIFO_AW-1:0]];

endmodule

//--- source/imem_loader.sv
// Frame parser that writes received words into instruction memory and queues the reply
`timescale 1ns/1ps

module imem_loader (
   input  logic                     clk,
   input  logic                     arst_n,
   input  loader_pkg::uart_byte_t   rx_head,
   input  logic                     rx_empty,
   output logic                     rx_pop,
   input  logic                     tx_full,
   output loader_pkg::byte_strobe_t tx_push,
   output loader_pkg::imem_wr_t     imem_wr,
   output logic                     cpu_rstn
);

   // Frame positions, in wire order
   typedef enum logic [2:0] {
      fr_wait_sop,
      fr_command,
      fr_length_low,
      fr_length_high,
      fr_data,
      fr_checksum,
      fr_eop,
      fr_reply
   } frame_state_t;

   frame_state_t                              state;
   logic                                      take;
   logic                                      last_byte;
   logic                                      last_word;
   logic [$clog2(loader_pkg::WORD_BYTES)-1:0] byte_cnt;
   logic [15:0]                               word_cnt;
   logic [15:0]                               frame_len;
   logic                                      wr_en;
   logic [29:0]                               wr_addr;
   logic [31:0]                               word_sr;
   loader_pkg::uart_byte_t                    csum;
   logic                                      csum_ok;
   loader_pkg::uart_byte_t                    reply_byte;

   // ------------------------------------------------------------------
   // Byte intake
   // ------------------------------------------------------------------
   // One byte per cycle, intake pauses while the reply is pending
   assign take      = !rx_empty && (state != fr_reply);
   assign rx_pop    = take;
   assign last_byte = (byte_cnt == loader_pkg::WORD_BYTES - 1);
   assign last_word = (word_cnt == frame_len - 16'd1);

   // ------------------------------------------------------------------
   // Frame FSM
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         state    <= fr_wait_sop;
         cpu_rstn <= 1'b1;
         wr_en    <= 1'b0;
         byte_cnt <= '0;
         word_cnt <= '0;
      end else begin
         // Write strobe lasts one cycle
         wr_en <= 1'b0;
         case (state)
            // Anything but SOP is dropped here
            fr_wait_sop: begin
               if (take && (rx_head == loader_pkg::SOP_BYTE)) begin
                  state    <= fr_command;
                  cpu_rstn <= 1'b0;
                  byte_cnt <= '0;
                  word_cnt <= '0;
               end
            end
            // Command byte is passed over
            fr_command: if (take) state <= fr_length_low;
            fr_length_low: if (take) state <= fr_length_high;
            fr_length_high: if (take) state <= fr_data;
            fr_data: begin
               if (take) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (last_byte) begin
                     wr_en    <= 1'b1;
                     word_cnt <= word_cnt + 16'd1;
                     if (last_word) begin
                        state <= fr_checksum;
                     end
                  end
               end
            end
            fr_checksum: if (take) state <= fr_eop;
            fr_eop: if (take) state <= fr_reply;
            // Wait for room, then release the CPU
            fr_reply: begin
               if (tx_push.valid) begin
                  state    <= fr_wait_sop;
                  cpu_rstn <= 1'b1;
               end
            end
            default: state <= fr_wait_sop;
         endcase
      end
   end

   // ------------------------------------------------------------------
   // Word assembly, checksum and reply selection
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (take) begin
         case (state)
            fr_wait_sop: csum <= '0;
            fr_length_low: frame_len[7:0] <= rx_head;
            fr_length_high: frame_len[15:8] <= rx_head;
            fr_data: begin
               // Little endian, first byte ends up in bits 7:0
               word_sr <= {rx_head, word_sr[31:8]};
               csum    <= csum + rx_head;
               if (last_byte) begin
                  wr_addr <= {14'd0, word_cnt};
               end
            end
            fr_checksum: csum_ok <= (rx_head == csum);
            // Failure returns the computed sum to the host
            fr_eop: begin
               if (csum_ok && (rx_head == loader_pkg::EOP_BYTE)) begin
                  reply_byte <= loader_pkg::ACK_BYTE;
               end else begin
                  reply_byte <= csum;
               end
            end
            default: begin
            end
         endcase
      end
   end

   assign tx_push = '{valid: (state == fr_reply) && !tx_full, data: reply_byte};
   assign imem_wr = '{we: wr_en, waddr: wr_addr, wdat: word_sr};

endmodule

//--- source/loader_pkg.sv
// Shared constants, UART bit-timing tables and bus types for the serial program loader
package loader_pkg;

   // ------------------------------------------------------------------
   // Time base
   // ------------------------------------------------------------------
   // Clocks per microsecond at 25 MHz
   localparam int NUM_1US_CLKS = 25;
   // Width of the microsecond divider
   localparam int DIV_W = $clog2(NUM_1US_CLKS);
   // Width of the per-bit tick countdown
   localparam int CNT_W = 4;

   // Rx waits, each entry counts N+1 ticks
   // Entry 0 skips start and lands near the centre of D0
   // Entries 1..8 cover D1 through D7 and then stop
   localparam logic [CNT_W-1:0] RX_WAIT_TABLE [9] = '{
      4'd13, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8
   };

   // Tx waits for start, D0..D7 and stop
   // Start gets one extra tick for alignment to the time base
   localparam logic [CNT_W-1:0] TX_WAIT_TABLE [10] = '{
      4'd9, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8
   };

   // FIFO depth is 2**FIFO_AW
   localparam int FIFO_AW = 4;

   // ------------------------------------------------------------------
   // Types and frame markers
   // ------------------------------------------------------------------
   typedef logic [7:0] uart_byte_t;

   localparam uart_byte_t SOP_BYTE = 8'h12;
   localparam uart_byte_t EOP_BYTE = 8'h14;
   localparam uart_byte_t ACK_BYTE = 8'h55;
   localparam int WORD_BYTES = 4;

   // Data positions equal the bit index, so a table lookup is state + 1
   typedef enum logic [3:0] {
      bit_d0    = 4'd0,
      bit_d1    = 4'd1,
      bit_d2    = 4'd2,
      bit_d3    = 4'd3,
      bit_d4    = 4'd4,
      bit_d5    = 4'd5,
      bit_d6    = 4'd6,
      bit_d7    = 4'd7,
      bit_stop  = 4'd8,
      bit_idle  = 4'd14,
      bit_start = 4'd15
   } bit_state_t;

   // One instruction memory write, word addressed
   typedef struct packed {
      logic        we;
      logic [29:0] waddr;
      logic [31:0] wdat;
   } imem_wr_t;

   // Single-cycle byte push between stages
   typedef struct packed {
      logic       valid;
      uart_byte_t data;
   } byte_strobe_t;

endpackage

//--- source/tick_gen.sv
// Microsecond time base, a one-cycle tick shared by the UART receiver and transmitter
`timescale 1ns/1ps

module tick_gen (
   input  logic clk,
   input  logic arst_n,
   output logic tick_1us
);

   // Free-running divider, wraps every NUM_1US_CLKS clocks
   logic [loader_pkg::DIV_W-1:0] div_cnt;

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         div_cnt  <= '0;
         tick_1us <= 1'b0;
      end else if (div_cnt == loader_pkg::NUM_1US_CLKS - 1) begin
         // Last clock of the microsecond
         div_cnt  <= '0;
         tick_1us <= 1'b1;
      end else begin
         div_cnt  <= div_cnt + 1'b1;
         tick_1us <= 1'b0;
      end
   end

endmodule

//--- source/uart_loader_top.sv
// Top level of the serial program loader, chains UART, FIFOs and frame loader
`timescale 1ns/1ps

module uart_loader_top (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 rx,
   output logic                 tx,
   output loader_pkg::imem_wr_t imem_wr,
   output logic                 cpu_rstn
);

   logic                     tick_1us;
   loader_pkg::byte_strobe_t rx_byte;
   loader_pkg::uart_byte_t   rx_head;
   logic                     rx_empty;
   logic                     rx_pop;
   loader_pkg::byte_strobe_t tx_push;
   loader_pkg::uart_byte_t   tx_head;
   logic                     tx_empty;
   logic                     tx_full;
   logic                     tx_pop;

   // ------------------------------------------------------------------
   // Receive path
   // ------------------------------------------------------------------
   tick_gen u_tick (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us)
   );

   uart_rx u_rx (
      .clk      (clk),
      .arst_n   (arst_n),
      .rx       (rx),
      .tick_1us (tick_1us),
      .rx_byte  (rx_byte)
   );

   // Bytes beyond the depth are dropped inside the FIFO
   byte_fifo u_rx_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .push   (rx_byte),
      .pop    (rx_pop),
      .head   (rx_head),
      .empty  (rx_empty),
      .full   ()
   );

   // ------------------------------------------------------------------
   // Loader and reply path
   // ------------------------------------------------------------------
   imem_loader u_loader (
      .clk      (clk),
      .arst_n   (arst_n),
      .rx_head  (rx_head),
      .rx_empty (rx_empty),
      .rx_pop   (rx_pop),
      .tx_full  (tx_full),
      .tx_push  (tx_push),
      .imem_wr  (imem_wr),
      .cpu_rstn (cpu_rstn)
   );

   byte_fifo u_tx_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .push   (tx_push),
      .pop    (tx_pop),
      .head   (tx_head),
      .empty  (tx_empty),
      .full   (tx_full)
   );

   uart_tx u_tx (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us),
      .tx_head  (tx_head),
      .tx_empty (tx_empty),
      .tx_pop   (tx_pop),
      .tx       (tx)
   );

endmodule

//--- source/uart_rx.sv
// UART receiver, 8N1 at 115.2 kbit/s, samples on the 1 us tick and pushes each byte
`timescale 1ns/1ps

module uart_rx (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     rx,
   input  logic                     tick_1us,
   output loader_pkg::byte_strobe_t rx_byte
);

   // ------------------------------------------------------------------
   // Input synchronizer
   // ------------------------------------------------------------------
   // Line idles high
   logic [1:0] rx_sync;
   logic       rx_bit;

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], rx};
      end
   end

   assign rx_bit = rx_sync[1];

   // ------------------------------------------------------------------
   // Bit FSM
   // ------------------------------------------------------------------
   loader_pkg::bit_state_t       rx_state;
   logic [loader_pkg::CNT_W-1:0] rx_cnt;
   logic                         rx_next;
   logic [3:0]                   next_pos;
   loader_pkg::uart_byte_t       rx_shift;

   // Sampling point reached
   assign rx_next  = tick_1us && (rx_cnt == '0);
   // Following bit position, also the index of its wait
   assign next_pos = rx_state + 4'd1;

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_state <= loader_pkg::bit_idle;
         rx_cnt   <= '0;
      end else begin
         // Count down ticks while a character is in flight
         if (tick_1us && (rx_state != loader_pkg::bit_idle)) begin
            rx_cnt <= rx_cnt - 1'b1;
         end
         case (rx_state)
            // Start bit is folded into the first wait
            loader_pkg::bit_idle: begin
               rx_cnt <= loader_pkg::RX_WAIT_TABLE[0];
               if (!rx_bit) begin
                  rx_state <= loader_pkg::bit_d0;
               end
            end
            loader_pkg::bit_stop: begin
               if (rx_next) begin
                  rx_state <= loader_pkg::bit_idle;
               end
            end
            // D0..D7, a load here overrides the countdown
            default: begin
               if (rx_next) begin
                  rx_cnt   <= loader_pkg::RX_WAIT_TABLE[next_pos];
                  rx_state <= loader_pkg::bit_state_t'(next_pos);
               end
            end
         endcase
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk) begin
      if (rx_next && (rx_state inside {[loader_pkg::bit_d0:loader_pkg::bit_d7]})) begin
         rx_shift <= {rx_bit, rx_shift[7:1]};
      end
   end

   // Push in the middle of the stop bit
   assign rx_byte = '{valid: rx_next && (rx_state == loader_pkg::bit_stop), data: rx_shift};

endmodule

//--- source/uart_tx.sv
// UART transmitter, 8N1 at 115.2 kbit/s, sends queued bytes on the 1 us tick
`timescale 1ns/1ps

module uart_tx (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   tick_1us,
   input  loader_pkg::uart_byte_t tx_head,
   input  logic                   tx_empty,
   output logic                   tx_pop,
   output logic                   tx
);

   loader_pkg::bit_state_t       tx_state;
   logic [loader_pkg::CNT_W-1:0] tx_cnt;
   logic                         tx_next;
   logic [3:0]                   next_pos;

   // End of the current bit
   assign tx_next  = tick_1us && (tx_cnt == '0);
   assign next_pos = tx_state + 4'd1;
   // Head byte leaves the FIFO once its stop bit is done
   assign tx_pop   = tx_next && (tx_state == loader_pkg::bit_stop);

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         tx_state <= loader_pkg::bit_idle;
         tx_cnt   <= '0;
         tx       <= 1'b1;
      end else begin
         if (tick_1us && (tx_state != loader_pkg::bit_idle)) begin
            tx_cnt <= tx_cnt - 1'b1;
         end
         case (tx_state)
            // Line held at mark level
            loader_pkg::bit_idle: begin
               tx     <= 1'b1;
               tx_cnt <= loader_pkg::TX_WAIT_TABLE[0];
               if (!tx_empty) begin
                  tx_state <= loader_pkg::bit_start;
               end
            end
            // Start bit begins on the first tick after data shows up
            loader_pkg::bit_start: begin
               if (tick_1us) begin
                  tx <= 1'b0;
                  if (tx_cnt == '0) begin
                     tx       <= tx_head[0];
                     tx_cnt   <= loader_pkg::TX_WAIT_TABLE[1];
                     tx_state <= loader_pkg::bit_d0;
                  end
               end
            end
            loader_pkg::bit_stop: begin
               if (tx_next) begin
                  tx_state <= loader_pkg::bit_idle;
               end
            end
            // D0..D7, table is one entry ahead because of start
            default: begin
               if (tx_next) begin
                  tx_cnt   <= loader_pkg::TX_WAIT_TABLE[next_pos + 4'd1];
                  tx_state <= loader_pkg::bit_state_t'(next_pos);
                  if (tx_state == loader_pkg::bit_d7) begin
                     tx <= 1'b1;
                  end else begin
                     tx <= tx_head[next_pos[2:0]];
                  end
               end
            end
         endcase
      end
   end

endmodule

//--- test/tb_uart_loader.sv
// Testbench for the serial program loader, sends framed packets on rx and checks writes and replies
`timescale 1ns/1ps

module tb_uart_loader;

   // One row per frame, word 0 sits in the low 32 bits of words
   typedef struct packed {
      logic [1:0]       garbage;
      logic [15:0]      len;
      logic [3:0][31:0] words;
      logic             bad_csum;
      logic             bad_eop;
      logic             exp_ack;
   } frame_row_t;

   logic                   clk;
   logic                   arst_n;
   logic                   rx;
   logic                   tx;
   loader_pkg::imem_wr_t   imem_wr;
   logic                   cpu_rstn;

   frame_row_t             rows [5];
   loader_pkg::imem_wr_t   wr_q [$];
   loader_pkg::uart_byte_t reply_q [$];
   integer                 seed;
   int                     cycle_cnt;
   int                     cycle_limit;
   int                     wr_errs;
   int                     reply_errs;
   int                     ctl_errs;

   uart_loader_top uut (
      .clk      (clk),
      .arst_n   (arst_n),
      .rx       (rx),
      .tx       (tx),
      .imem_wr  (imem_wr),
      .cpu_rstn (cpu_rstn)
   );

   // ------------------------------------------------------------------
   // Clock, timeout and monitors
   // ------------------------------------------------------------------
   // 25 MHz
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if ((cycle_limit != 0) && (cycle_cnt > cycle_limit)) begin
         $display("Timeout: run still busy after %0d cycles, stopped", cycle_cnt);
         $display("Testbench failed");
         $finish;
      end
   end

   // Every write pulse of the current frame
   always @(negedge clk) begin
      if (arst_n && (imem_wr.we === 1'b1)) begin
         wr_q.push_back(imem_wr);
      end
   end

   // Reply decoder, 217 cycles per bit, samples at mid-bit
   initial begin : reply_decoder
      loader_pkg::uart_byte_t shift;
      forever begin
         @(negedge clk);
         if (arst_n && (tx === 1'b0)) begin
            repeat (108) @(negedge clk);
            assert (tx === 1'b0) else begin
               reply_errs++;
               $display("ERR %0t: reply start bit not low at its centre", $time);
            end
            // LSB first
            for (int i = 0; i < 8; i++) begin
               repeat (217) @(negedge clk);
               shift[i] = tx;
            end
            repeat (217) @(negedge clk);
            assert (tx === 1'b1) else begin
               reply_errs++;
               $display("ERR %0t: reply stop bit not high", $time);
            end
            reply_q.push_back(shift);
         end
      end
   end

   // ------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------
   // One bit time on rx, entered and left on a falling edge
   task automatic drive_bit(input logic level);
      rx = level;
      repeat (217) @(negedge clk);
   endtask

   task automatic send_byte(input loader_pkg::uart_byte_t data);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         drive_bit(data[i]);
      end
      drive_bit(1'b1);
   endtask

   // Modulo 256 sum of the data bytes only
   function automatic loader_pkg::uart_byte_t data_checksum(input frame_row_t row);
      loader_pkg::uart_byte_t sum;
      sum = '0;
      for (int w = 0; w < row.len; w++) begin
         for (int b = 0; b < 4; b++) begin
            sum = sum + row.words[w][8*b +: 8];
         end
      end
      return sum;
   endfunction

   // Serial time of all table bytes plus slack per row, doubled
   function automatic int run_cycles();
      int bytes;
      bytes = 0;
      foreach (rows[r]) begin
         bytes += rows[r].garbage + 6 + 4 * rows[r].len;
      end
      return 2 * (bytes * 10 * 217 + 2000 * $size(rows));
   endfunction

   task automatic fill_table();
      rows[0] = '{garbage: 2'd0, len: 16'd1,
                  words: {32'h0, 32'h0, 32'h0, 32'h0403_0201},
                  bad_csum: 1'b0, bad_eop: 1'b0, exp_ack: 1'b1};
      rows[1] = '{garbage: 2'd2, len: 16'd4,
                  words: {32'h0F1E_2D3C, 32'h89AB_CDEF, 32'h0123_4567, 32'hDEAD_BEEF},
                  bad_csum: 1'b0, bad_eop: 1'b0, exp_ack: 1'b1};
      // Marker values inside the payload
      rows[2] = '{garbage: 2'd0, len: 16'd2,
                  words: {32'h0, 32'h0, 32'h1212_1414, 32'hCAFE_F00D},
                  bad_csum: 1'b1, bad_eop: 1'b0, exp_ack: 1'b0};
      rows[3] = '{garbage: 2'd1, len: 16'd3,
                  words: {32'h0, 32'h5555_AAAA, 32'h0000_0000, 32'hFFFF_FFFF},
                  bad_csum: 1'b0, bad_eop: 1'b1, exp_ack: 1'b0};
      rows[4] = '{garbage: 2'd3, len: 16'd2,
                  words: {32'h0, 32'h0, 32'h7654_3210, 32'h1357_9BDF},
                  bad_csum: 1'b1, bad_eop: 1'b1, exp_ack: 1'b0};
   endtask

   task automatic check_frame(input frame_row_t row, input loader_pkg::uart_byte_t exp_sum);
      loader_pkg::uart_byte_t exp_reply;
      loader_pkg::uart_byte_t got;
      exp_reply = row.exp_ack ? loader_pkg::ACK_BYTE : exp_sum;
      // Reply shows up about one character after EOP
      while (reply_q.size() == 0) begin
         @(negedge clk);
      end
      got = reply_q.pop_front();
      assert (got == exp_reply) else begin
         reply_errs++;
         $display("ERR %0t: reply %h, expected %h", $time, got, exp_reply);
      end
      assert (cpu_rstn === 1'b1) else begin
         ctl_errs++;
         $display("ERR %0t: cpu_rstn still low after the reply", $time);
      end
      assert (wr_q.size() == row.len) else begin
         wr_errs++;
         $display("ERR %0t: %0d writes, expected %0d", $time, wr_q.size(), row.len);
      end
      for (int i = 0; (i < wr_q.size()) && (i < 4); i++) begin
         assert ((wr_q[i].waddr == i) && (wr_q[i].wdat == row.words[i])) else begin
            wr_errs++;
            $display("ERR %0t: write %0d went to %0d with %h, expected %h", $time, i,
                     wr_q[i].waddr, wr_q[i].wdat, row.words[i]);
         end
      end
   endtask

   // ------------------------------------------------------------------
   // Stimulus loop
   // ------------------------------------------------------------------
   initial begin : main
      frame_row_t             row;
      loader_pkg::uart_byte_t exp_sum;
      int                     gap;
      int                     chk_errs;
      clk         = 1'b0;
      arst_n      = 1'b0;
      rx          = 1'b1;
      seed        = 5221;
      cycle_cnt   = 0;
      wr_errs     = 0;
      reply_errs  = 0;
      ctl_errs    = 0;
      fill_table();
      cycle_limit = run_cycles();
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      assert ((tx === 1'b1) && (imem_wr.we === 1'b0) && (cpu_rstn === 1'b1)) else begin
         ctl_errs++;
         $display("ERR %0t: outputs not at their idle levels after reset", $time);
      end
      foreach (rows[r]) begin
         row     = rows[r];
         exp_sum = data_checksum(row);
         wr_q.delete();
         gap = 20 + ({$random(seed)} % 300);
         repeat (gap) @(negedge clk);
         // Leading bytes that the loader must drop
         for (int g = 0; g < row.garbage; g++) begin
            send_byte(loader_pkg::uart_byte_t'(8'hA0 + g));
         end
         assert ((reply_q.size() == 0) && (wr_q.size() == 0)) else begin
            ctl_errs++;
            $display("ERR %0t: garbage before SOP caused a write or reply", $time);
         end
         send_byte(loader_pkg::SOP_BYTE);
         send_byte(8'h01);
         send_byte(row.len[7:0]);
         send_byte(row.len[15:8]);
         for (int w = 0; w < row.len; w++) begin
            for (int b = 0; b < 4; b++) begin
               send_byte(row.words[w][8*b +: 8]);
            end
         end
         send_byte(row.bad_csum ? ~exp_sum : exp_sum);
         // CPU held in reset while the frame is open
         assert (cpu_rstn === 1'b0) else begin
            ctl_errs++;
            $display("ERR %0t: cpu_rstn high in the middle of a frame", $time);
         end
         send_byte(row.bad_eop ? (loader_pkg::EOP_BYTE ^ 8'h01) : loader_pkg::EOP_BYTE);
         check_frame(row, exp_sum);
      end
      repeat (3000) @(negedge clk);
      assert (reply_q.size() == 0) else begin
         reply_errs++;
         $display("ERR %0t: stray reply byte after the last frame", $time);
      end
      // Property failures seen by the bound checker
      chk_errs = uut.u_chk.single_errs + uut.u_chk.reset_errs + uut.u_chk.idle_errs;
      $display("Errors: %0d write, %0d reply, %0d control, %0d protocol",
               wr_errs, reply_errs, ctl_errs, chk_errs);
      if ((wr_errs + reply_errs + ctl_errs + chk_errs) == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- test/uart_loader_chk.sv
// Protocol assertions on the loader top level, attached to the DUT through bind
`timescale 1ns/1ps

module uart_loader_chk (
   input logic                 clk,
   input logic                 arst_n,
   input logic                 tx,
   input logic                 tx_empty,
   input loader_pkg::imem_wr_t imem_wr,
   input logic                 cpu_rstn
);

   // Failure counts per property
   int single_errs = 0;
   int reset_errs  = 0;
   int idle_errs   = 0;

   // Write strobe lasts one cycle
   we_single: assert property (@(posedge clk) disable iff (!arst_n)
      imem_wr.we |=> !imem_wr.we)
      else begin
         single_errs++;
         $error("imem write strobe high for two cycles in a row");
      end

   // Writes only while the CPU is held in reset
   we_in_reset: assert property (@(posedge clk) disable iff (!arst_n)
      imem_wr.we |-> !cpu_rstn)
      else begin
         reset_errs++;
         $error("imem write while cpu_rstn is high");
      end

   // Nothing queued means the transmitter idles at mark level
   tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
      tx_empty |-> tx)
      else begin
         idle_errs++;
         $error("tx low while the transmitter is idle");
      end

endmodule

bind uart_loader_top uart_loader_chk u_chk (
   .clk      (clk),
   .arst_n   (arst_n),
   .tx       (tx),
   .tx_empty (tx_empty),
   .imem_wr  (imem_wr),
   .cpu_rstn (cpu_rstn)
);
